// File: hw/radio_defs.svh
// Board constants shared by the TX core blocks
// RB_SCLK_HALF sets the converter serial clock to pi_tx_clk / (2 * RB_SCLK_HALF)
`ifndef RADIO_DEFS_SVH
`define RADIO_DEFS_SVH

// Version bytes returned on miso during every frame
`define RB_VERSION_MAJOR 8'd71
`define RB_VERSION_MINOR 8'd1

// Command frame length in SPI clocks
`define RB_FRAME_BITS 48

// Command address forwarded as a raw converter write
`define RB_CODEC_CMD_ADDR 6'h3C
// Converter register selecting TX or RX
`define RB_TXEN_REG 8'h0E

// Clock cycles per half period of the converter serial clock
`define RB_SCLK_HALF 2

`endif

// File: hw/radio_pkg.sv
// Shared types of the TX core
// Widths here must agree with the frame layout in radio_defs.svh
`default_nettype none

package radio_pkg;

  // Command frame fields
  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;

  // Converter control word, register address high, value low
  typedef logic [15:0] ctrl_word_t;

  // TX sample stream
  typedef logic [3:0]  nibble_t;
  typedef logic [31:0] iq_word_t;

  // Control port serializer
  typedef enum logic [1:0] {IDLE, SHIFT, DONE} ser_state_t;

  // PTT sequencing, write states sit between the two stable states
  typedef enum logic [1:0] {RX, WR_TX, TX, WR_RX} ptt_state_t;

endpackage

`default_nettype wire

// File: hw/spi_cmd_slave.sv
// SPI mode 0 command port on pi_spi_ce[0], ce[1] belongs to another slave
// pi_spi_sck must run at no more than one eighth of pi_tx_clk
`default_nettype none
`include "radio_defs.svh"

module spi_cmd_slave (
  input  wire                    pi_tx_clk,
  input  wire                    rst_n,
  input  wire                    pi_spi_sck,
  input  wire                    pi_spi_mosi,
  input  wire  [1:0]             pi_spi_ce,
  output logic                   pi_spi_miso,
  output logic                   run,
  output logic                   ptt,
  output logic                   host_req,
  output radio_pkg::ctrl_word_t  host_word,
  input  wire                    host_done
);

  localparam logic [`RB_FRAME_BITS-1:0] VERSION_WORD =
    {32'h0, `RB_VERSION_MAJOR, `RB_VERSION_MINOR};

  // Stage 0 newest, stage 1 synchronized, stage 2 previous
  logic [2:0] sck_pipe;
  logic [2:0] ce_pipe;
  logic [1:0] mosi_pipe;
  logic       sck_rise;
  logic       sck_fall;
  logic       ce_rise;

  logic [`RB_FRAME_BITS-1:0] rx_shift;
  logic [`RB_FRAME_BITS-1:0] tx_shift;
  logic [6:0]                bit_cnt;
  logic                      accept_q;
  logic                      cmd_strobe;
  radio_pkg::cmd_addr_t      cmd_addr;
  radio_pkg::cmd_data_t      cmd_data;

  assign sck_rise = sck_pipe[1] & ~sck_pipe[2];
  assign sck_fall = ~sck_pipe[1] & sck_pipe[2];
  assign ce_rise  = ce_pipe[1] & ~ce_pipe[2];

  // Frame fields, stable while ce stays high
  assign cmd_addr = rx_shift[38:33];
  assign cmd_data = rx_shift[31:0];

  // Idle high while deselected
  assign pi_spi_miso = ce_pipe[1] ? 1'b1 : tx_shift[`RB_FRAME_BITS-1];

  // ------------------------------
  // Synchronizers and bit counter
  // ------------------------------
  always_ff @(posedge pi_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      sck_pipe   <= '0;
      ce_pipe    <= '1;
      mosi_pipe  <= '0;
      bit_cnt    <= '0;
      accept_q   <= 1'b0;
      cmd_strobe <= 1'b0;
    end else begin
      sck_pipe  <= {sck_pipe[1:0], pi_spi_sck};
      ce_pipe   <= {ce_pipe[1:0], pi_spi_ce[0]};
      mosi_pipe <= {mosi_pipe[0], pi_spi_mosi};
      // Only an exact frame length is accepted
      accept_q   <= ce_rise && (bit_cnt == 7'(`RB_FRAME_BITS));
      cmd_strobe <= accept_q;
      if (ce_pipe[1]) begin
        bit_cnt <= '0;
      end else if (sck_rise && bit_cnt != 7'h7f) begin
        // Saturates so long frames never wrap back to 48
        bit_cnt <= bit_cnt + 7'd1;
      end
    end
  end

  // Shift registers, MSB first both ways
  always_ff @(posedge pi_tx_clk) begin
    if (!ce_pipe[1] && sck_rise) begin
      rx_shift <= {rx_shift[`RB_FRAME_BITS-2:0], mosi_pipe[1]};
    end
    if (ce_pipe[1]) begin
      tx_shift <= VERSION_WORD;
    end else if (sck_fall) begin
      tx_shift <= {tx_shift[`RB_FRAME_BITS-2:0], 1'b0};
    end
  end

  // ------------------------------
  // Command decode
  // ------------------------------
  always_ff @(posedge pi_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      run      <= 1'b0;
      ptt      <= 1'b0;
      host_req <= 1'b0;
    end else begin
      if (cmd_strobe) begin
        run <= rx_shift[40];
        ptt <= rx_shift[32];
      end
      // Codec frames are dropped while a write is still pending
      if (host_done) begin
        host_req <= 1'b0;
      end else if (cmd_strobe && cmd_addr == `RB_CODEC_CMD_ADDR && !host_req) begin
        host_req <= 1'b1;
      end
    end
  end

  always_ff @(posedge pi_tx_clk) begin
    if (cmd_strobe && cmd_addr == `RB_CODEC_CMD_ADDR && !host_req) begin
      host_word <= cmd_data[15:0];
    end
  end

endmodule

`default_nettype wire

// File: hw/tx_stream_packer.sv
// One nibble per pi_tx_clk, captured on the falling edge while run is high
// Dropping run discards the partial word and restarts the frame count
`default_nettype none

module tx_stream_packer (
  input  wire                  pi_tx_clk,
  input  wire                  rst_n,
  input  wire  [3:0]           pi_tx_data,
  input  wire                  run,
  output radio_pkg::iq_word_t  tx_word,
  output logic                 tx_word_valid,
  output logic                 tx_frame_last
);

  radio_pkg::nibble_t nib_fall;
  logic               nib_fall_vld;
  logic [2:0]         nib_cnt;
  logic [1:0]         word_cnt;
  // First seven nibbles of the current word
  logic [27:0]        word_acc;

  // Falling edge capture
  always_ff @(negedge pi_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      nib_fall_vld <= 1'b0;
    end else begin
      nib_fall_vld <= run;
    end
  end

  always_ff @(negedge pi_tx_clk) begin
    nib_fall <= pi_tx_data;
  end

  // ------------------------------
  // Counters and word strobe
  // ------------------------------
  always_ff @(posedge pi_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      nib_cnt       <= '0;
      word_cnt      <= '0;
      tx_word_valid <= 1'b0;
      tx_frame_last <= 1'b0;
    end else begin
      tx_word_valid <= 1'b0;
      if (!run) begin
        nib_cnt  <= '0;
        word_cnt <= '0;
      end else if (nib_fall_vld) begin
        nib_cnt <= nib_cnt + 3'd1;
        if (nib_cnt == 3'd7) begin
          tx_word_valid <= 1'b1;
          // Every fourth word closes a frame
          tx_frame_last <= (word_cnt == 2'd3);
          word_cnt      <= word_cnt + 2'd1;
        end
      end
    end
  end

  // Nibble n lands in bits 4n+3..4n, low nibble and low byte first
  always_ff @(posedge pi_tx_clk) begin
    if (run && nib_fall_vld) begin
      if (nib_cnt == 3'd7) begin
        tx_word <= {nib_fall, word_acc};
      end else begin
        word_acc[{nib_cnt, 2'b00} +: 4] <= nib_fall;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/ptt_sequencer.sv
// Keys the PA only after the converter is in TX, unkeys before going back
// Requested state is run AND ptt, sampled every cycle
`default_nettype none
`include "radio_defs.svh"

module ptt_sequencer (
  input  wire                    pi_tx_clk,
  input  wire                    rst_n,
  input  wire                    run,
  input  wire                    ptt,
  output logic                   ptt_req,
  output radio_pkg::ctrl_word_t  ptt_word,
  input  wire                    ptt_done,
  output logic                   io_ptt_out
);

  radio_pkg::ptt_state_t state;
  logic                  want_tx;

  assign want_tx = run & ptt;

  // Request held for the whole write state
  assign ptt_req  = (state == radio_pkg::WR_TX) || (state == radio_pkg::WR_RX);
  // Value 01 selects TX, 00 selects RX
  assign ptt_word = {`RB_TXEN_REG, 7'd0, state == radio_pkg::WR_TX};

  // ------------------------------
  // Sequencing FSM
  // ------------------------------
  always_ff @(posedge pi_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= radio_pkg::RX;
      io_ptt_out <= 1'b0;
    end else begin
      case (state)
        radio_pkg::RX: begin
          if (want_tx) begin
            state <= radio_pkg::WR_TX;
          end
        end
        radio_pkg::WR_TX: begin
          // PA keyed in the cycle after the TX write completes
          if (ptt_done) begin
            state      <= radio_pkg::TX;
            io_ptt_out <= 1'b1;
          end
        end
        radio_pkg::TX: begin
          // Unkey together with the RX write request
          if (!want_tx) begin
            state      <= radio_pkg::WR_RX;
            io_ptt_out <= 1'b0;
          end
        end
        radio_pkg::WR_RX: begin
          if (ptt_done) begin
            state <= radio_pkg::RX;
          end
        end
        default: begin
          state      <= radio_pkg::RX;
          io_ptt_out <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/ctrl_port_arbiter.sv
// Fixed priority, ptt over host, one write in flight at a time
// Requesters hold their level request until their done pulse
`default_nettype none

module ctrl_port_arbiter (
  input  wire                    pi_tx_clk,
  input  wire                    rst_n,
  input  wire                    ptt_req,
  input  wire                    host_req,
  input  radio_pkg::ctrl_word_t  ptt_word,
  input  radio_pkg::ctrl_word_t  host_word,
  output logic                   ptt_done,
  output logic                   host_done,
  output logic                   ser_start,
  output radio_pkg::ctrl_word_t  ser_word,
  input  wire                    ser_done
);

  logic busy;
  // High when the ptt sequencer owns the port
  logic owner_ptt;

  // Done goes back only to the current owner
  assign ptt_done  = ser_done & busy & owner_ptt;
  assign host_done = ser_done & busy & ~owner_ptt;

  // ------------------------------
  // Grant
  // ------------------------------
  always_ff @(posedge pi_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      owner_ptt <= 1'b0;
      ser_start <= 1'b0;
    end else begin
      ser_start <= 1'b0;
      if (busy) begin
        // Port stays closed until the serializer finishes
        if (ser_done) begin
          busy <= 1'b0;
        end
      end else if (ptt_req) begin
        busy      <= 1'b1;
        owner_ptt <= 1'b1;
        ser_start <= 1'b1;
      end else if (host_req) begin
        busy      <= 1'b1;
        owner_ptt <= 1'b0;
        ser_start <= 1'b1;
      end
    end
  end

  // Word follows the same priority, frozen while busy
  always_ff @(posedge pi_tx_clk) begin
    if (!busy) begin
      ser_word <= ptt_req ? ptt_word : host_word;
    end
  end

endmodule

`default_nettype wire

// File: hw/ad9866_ctrl_serializer.sv
// 16-bit write, MSB first; sen_n low for 64 cycles with RB_SCLK_HALF of 2
// Start to done spans 66 cycles counting both; ser_start is ignored while busy
`default_nettype none
`include "radio_defs.svh"

module ad9866_ctrl_serializer (
  input  wire                    pi_tx_clk,
  input  wire                    rst_n,
  input  wire                    ser_start,
  input  radio_pkg::ctrl_word_t  ser_word,
  output logic                   ser_done,
  output logic                   rffe_ad9866_sclk,
  output logic                   rffe_ad9866_sdio,
  output logic                   rffe_ad9866_sen_n
);

  localparam int DIV_RISE = `RB_SCLK_HALF - 1;
  localparam int DIV_LAST = 2 * `RB_SCLK_HALF - 1;

  radio_pkg::ser_state_t state;
  logic [3:0]            div;
  logic [3:0]            bit_cnt;
  // Bits still to send, next one at the top
  logic [15:0]           shreg;

  // Done cycle is also the first cycle with sen_n high again
  assign ser_done = (state == radio_pkg::DONE);

  // ------------------------------
  // Serial FSM
  // ------------------------------
  always_ff @(posedge pi_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      state             <= radio_pkg::IDLE;
      div               <= '0;
      bit_cnt           <= '0;
      rffe_ad9866_sclk  <= 1'b0;
      rffe_ad9866_sdio  <= 1'b0;
      rffe_ad9866_sen_n <= 1'b1;
    end else begin
      case (state)
        radio_pkg::IDLE: begin
          if (ser_start) begin
            state             <= radio_pkg::SHIFT;
            div               <= '0;
            bit_cnt           <= '0;
            rffe_ad9866_sen_n <= 1'b0;
            rffe_ad9866_sdio  <= ser_word[15];
          end
        end
        radio_pkg::SHIFT: begin
          div <= div + 4'd1;
          if (div == 4'(DIV_RISE)) begin
            rffe_ad9866_sclk <= 1'b1;
          end
          // End of high phase, next bit goes out with sclk low
          if (div == 4'(DIV_LAST)) begin
            div              <= '0;
            rffe_ad9866_sclk <= 1'b0;
            if (bit_cnt == 4'd15) begin
              state             <= radio_pkg::DONE;
              rffe_ad9866_sen_n <= 1'b1;
            end else begin
              bit_cnt          <= bit_cnt + 4'd1;
              rffe_ad9866_sdio <= shreg[15];
            end
          end
        end
        default: begin
          state <= radio_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge pi_tx_clk) begin
    if (state == radio_pkg::IDLE && ser_start) begin
      shreg <= {ser_word[14:0], 1'b0};
    end else if (state == radio_pkg::SHIFT && div == 4'(DIV_LAST)) begin
      shreg <= {shreg[14:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

// File: hw/radioberry_tx_core.sv
// Single clock TX core, everything on pi_tx_clk
// No PLL, no RX path; pi_spi_ce[1] is left to another slave
`default_nettype none

module radioberry_tx_core (
  input  wire                  pi_tx_clk,
  input  wire                  rst_n,
  input  wire                  pi_spi_sck,
  input  wire                  pi_spi_mosi,
  input  wire  [1:0]           pi_spi_ce,
  output logic                 pi_spi_miso,
  input  wire  [3:0]           pi_tx_data,
  output radio_pkg::iq_word_t  tx_word,
  output logic                 tx_word_valid,
  output logic                 tx_frame_last,
  output logic                 rffe_ad9866_sclk,
  output logic                 rffe_ad9866_sdio,
  output logic                 rffe_ad9866_sen_n,
  output logic                 io_ptt_out
);

  // Command decode outputs
  logic                  run;
  logic                  ptt;
  // Control port requesters
  logic                  host_req;
  logic                  host_done;
  radio_pkg::ctrl_word_t host_word;
  logic                  ptt_req;
  logic                  ptt_done;
  radio_pkg::ctrl_word_t ptt_word;
  // Arbiter to serializer
  logic                  ser_start;
  logic                  ser_done;
  radio_pkg::ctrl_word_t ser_word;

  spi_cmd_slave i_spi_cmd_slave (
    .pi_tx_clk, .rst_n, .pi_spi_sck, .pi_spi_mosi, .pi_spi_ce, .pi_spi_miso,
    .run, .ptt, .host_req, .host_word, .host_done
  );

  tx_stream_packer i_tx_stream_packer (
    .pi_tx_clk, .rst_n, .pi_tx_data, .run, .tx_word, .tx_word_valid, .tx_frame_last
  );

  ptt_sequencer i_ptt_sequencer (
    .pi_tx_clk, .rst_n, .run, .ptt, .ptt_req, .ptt_word, .ptt_done, .io_ptt_out
  );

  ctrl_port_arbiter i_ctrl_port_arbiter (
    .pi_tx_clk, .rst_n, .ptt_req, .host_req, .ptt_word, .host_word,
    .ptt_done, .host_done, .ser_start, .ser_word, .ser_done
  );

  ad9866_ctrl_serializer i_ad9866_ctrl_serializer (
    .pi_tx_clk, .rst_n, .ser_start, .ser_word, .ser_done,
    .rffe_ad9866_sclk, .rffe_ad9866_sdio, .rffe_ad9866_sen_n
  );

endmodule

`default_nettype wire

// File: testbench/radioberry_tx_core_chk.sv
// Protocol checks on the converter control port and PA keying
// Written for the default RB_SCLK_HALF of 2
`default_nettype none

module radioberry_tx_core_chk (
  input wire        pi_tx_clk,
  input wire        rst_n,
  input wire        sen_n,
  input wire        ser_start,
  input wire        io_ptt_out,
  input wire        ptt_done,
  input wire [15:0] ptt_word
);
  timeunit 1ns;
  timeprecision 1ps;

  // Cycles that sen_n has been low so far
  logic [7:0] low_cnt;

  always_ff @(posedge pi_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      low_cnt <= '0;
    end else begin
      low_cnt <= sen_n ? 8'd0 : low_cnt + 8'd1;
    end
  end

  // One write keeps the port selected for 64 cycles
  sen_low_len: assert property (@(posedge pi_tx_clk) disable iff (!rst_n)
    $rose(sen_n) |-> low_cnt == 8'd64)
    else $error("sen_n low time differs from 64 cycles");

  // PA keyed only right after the TX write completes
  ptt_after_tx: assert property (@(posedge pi_tx_clk) disable iff (!rst_n)
    $rose(io_ptt_out) |-> $past(ptt_done && ptt_word[0]))
    else $error("io_ptt_out rose without a finished TX write");

  start_idle: assert property (@(posedge pi_tx_clk) disable iff (!rst_n)
    ser_start |-> sen_n)
    else $error("ser_start while the port was selected");

endmodule

bind radioberry_tx_core radioberry_tx_core_chk i_radioberry_tx_core_chk (
  .pi_tx_clk, .rst_n, .sen_n(rffe_ad9866_sen_n), .ser_start, .io_ptt_out,
  .ptt_done, .ptt_word
);

`default_nettype wire

// File: testbench/tb_radioberry_tx_core.sv
// Directed tests of the TX core; SPI runs at one eighth of pi_tx_clk
// Stops at the first mismatch or timeout
`default_nettype none
`include "radio_defs.svh"

module tb_radioberry_tx_core;
  timeunit 1ns;
  timeprecision 1ps;

  logic        pi_tx_clk;
  logic        rst_n;
  logic        pi_spi_sck;
  logic        pi_spi_mosi;
  logic [1:0]  pi_spi_ce;
  logic [3:0]  pi_tx_data;
  wire         pi_spi_miso;
  wire  [31:0] tx_word;
  wire         tx_word_valid;
  wire         tx_frame_last;
  wire         sclk;
  wire         sdio;
  wire         sen_n;
  wire         io_ptt_out;

  int          seed = 32'h2b87;
  // Expected words, frame-last flag in bit 32
  logic [32:0] exp_words[$];
  logic [31:0] acc;
  int          nib_cnt;
  int          word_cnt;
  int          words_seen;

  radioberry_tx_core i_radioberry_tx_core (
    .pi_tx_clk, .rst_n, .pi_spi_sck, .pi_spi_mosi, .pi_spi_ce, .pi_spi_miso,
    .pi_tx_data, .tx_word, .tx_word_valid, .tx_frame_last,
    .rffe_ad9866_sclk(sclk), .rffe_ad9866_sdio(sdio), .rffe_ad9866_sen_n(sen_n),
    .io_ptt_out
  );

  initial begin
    pi_tx_clk = 1'b0;
    forever #10 pi_tx_clk = ~pi_tx_clk;
  end

  // ------------------------------
  // Checking helpers
  // ------------------------------
  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %0h expected %0h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic stop_timeout(input string what);
    $display("Timed out waiting for %s at %0t", what, $time);
    $display("tests failed");
    $fatal(1);
  endtask

  function automatic logic [47:0] make_frame(input logic run_b, input logic ptt_b,
                                             input logic [5:0] addr, input logic [31:0] data);
    logic [47:0] f;
    f = '0;
    f[40] = run_b;
    f[38:33] = addr;
    f[32] = ptt_b;
    f[31:0] = data;
    return f;
  endfunction

  // Bit-bang one frame, mode 0, and collect miso before each rising sck
  task automatic send_frame(input logic [47:0] f, input int nbits, output logic [47:0] rx);
    rx = '0;
    pi_spi_ce <= 2'b10;
    repeat (8) @(posedge pi_tx_clk);
    for (int i = 0; i < nbits; i++) begin
      pi_spi_sck  <= 1'b0;
      pi_spi_mosi <= f[47-i];
      repeat (4) @(posedge pi_tx_clk);
      rx = {rx[46:0], pi_spi_miso};
      pi_spi_sck <= 1'b1;
      repeat (4) @(posedge pi_tx_clk);
    end
    pi_spi_sck <= 1'b0;
    repeat (4) @(posedge pi_tx_clk);
    pi_spi_ce <= 2'b11;
    repeat (8) @(posedge pi_tx_clk);
  endtask

  // Receive one control port write, sdio sampled on sclk rising edges
  task automatic recv_write(output logic [15:0] w);
    int   t;
    int   n;
    logic prev;
    t = 0;
    while (sen_n !== 1'b0) begin
      @(posedge pi_tx_clk);
      t++;
      if (t > 2000) stop_timeout("sen_n low");
    end
    n = 0;
    t = 0;
    prev = 1'b0;
    while (n < 16) begin
      @(posedge pi_tx_clk);
      if (sclk && !prev) begin
        w = {w[14:0], sdio};
        n++;
      end
      prev = sclk;
      t++;
      if (t > 200) stop_timeout("16 sclk edges");
    end
    t = 0;
    while (sen_n !== 1'b1) begin
      @(posedge pi_tx_clk);
      t++;
      if (t > 20) stop_timeout("sen_n high");
    end
  endtask

  task automatic no_write(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge pi_tx_clk);
      check_eq(sen_n, 1'b1, "unexpected control port write");
    end
  endtask

  task automatic wait_ptt(input logic level);
    int t;
    t = 0;
    while (io_ptt_out !== level) begin
      @(posedge pi_tx_clk);
      t++;
      if (t > 500) stop_timeout("io_ptt_out level");
    end
  endtask

  task automatic feed_nibbles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge pi_tx_clk);
      pi_tx_data <= 4'($random(seed));
    end
  endtask

  // ------------------------------
  // Packer reference model
  // ------------------------------
  always @(negedge pi_tx_clk) begin
    if (i_radioberry_tx_core.run === 1'b1) begin
      acc[nib_cnt*4 +: 4] = pi_tx_data;
      nib_cnt++;
      if (nib_cnt == 8) begin
        exp_words.push_back({word_cnt == 3, acc});
        word_cnt = (word_cnt + 1) % 4;
        nib_cnt = 0;
      end
    end else begin
      nib_cnt = 0;
      word_cnt = 0;
    end
  end

  always @(posedge pi_tx_clk) begin
    if (tx_word_valid === 1'b1) begin
      check_eq(exp_words.size() > 0, 1'b1, "word with none expected");
      check_eq({tx_frame_last, tx_word}, exp_words.pop_front(), "packed word");
      words_seen++;
    end
  end

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic test_version();
    logic [47:0] rx;
    send_frame(make_frame(0, 0, 6'h00, 32'h0), 48, rx);
    check_eq(rx, {32'h0, `RB_VERSION_MAJOR, `RB_VERSION_MINOR}, "version word");
  endtask

  task automatic test_host_write();
    logic [47:0] rx;
    logic [31:0] data;
    logic [15:0] w;
    data = $random(seed);
    send_frame(make_frame(0, 0, `RB_CODEC_CMD_ADDR, data), 48, rx);
    recv_write(w);
    check_eq(w, data[15:0], "host codec write");
    no_write(200);
    send_frame(make_frame(0, 0, 6'h01, $random(seed)), 48, rx);
    no_write(300);
  endtask

  task automatic test_ptt();
    logic [47:0] rx;
    logic [15:0] w;
    send_frame(make_frame(1, 1, 6'h00, 32'h0), 48, rx);
    recv_write(w);
    check_eq(w, {`RB_TXEN_REG, 8'h01}, "TX enable write");
    wait_ptt(1'b1);
    send_frame(make_frame(1, 0, 6'h00, 32'h0), 48, rx);
    // PA drops before the RX write leaves
    wait_ptt(1'b0);
    recv_write(w);
    check_eq(w, {`RB_TXEN_REG, 8'h00}, "RX enable write");
  endtask

  // Host request lands a cycle ahead of the ptt request and wins the idle port
  task automatic test_arbitration();
    logic [47:0] rx;
    logic [31:0] data;
    logic [15:0] w;
    data = $random(seed);
    send_frame(make_frame(1, 1, `RB_CODEC_CMD_ADDR, data), 48, rx);
    recv_write(w);
    check_eq(w, data[15:0], "host write ahead of waiting ptt");
    recv_write(w);
    check_eq(w, {`RB_TXEN_REG, 8'h01}, "waiting ptt write");
    wait_ptt(1'b1);
    send_frame(make_frame(0, 0, 6'h00, 32'h0), 48, rx);
    wait_ptt(1'b0);
    recv_write(w);
    check_eq(w, {`RB_TXEN_REG, 8'h00}, "ptt release write");
  endtask

  task automatic test_packing();
    logic [47:0] rx;
    int          start;
    start = words_seen;
    send_frame(make_frame(1, 0, 6'h00, 32'h0), 48, rx);
    feed_nibbles(8 * 9 + 3);
    // Drop run with a partial word in flight
    send_frame(make_frame(0, 0, 6'h00, 32'h0), 48, rx);
    feed_nibbles(20);
    send_frame(make_frame(1, 0, 6'h00, 32'h0), 48, rx);
    feed_nibbles(16);
    send_frame(make_frame(0, 0, 6'h00, 32'h0), 48, rx);
    check_eq(exp_words.size(), 0, "words left unsent");
    check_eq(words_seen - start > 8, 1'b1, "too few packed words");
  endtask

  // Short frame whose 40 bits line up as a codec write with run and ptt set
  task automatic test_bad_frame();
    logic [47:0] rx;
    logic [47:0] f;
    // Bit 0 set here so that a wrongly accepted short frame also sets run
    send_frame(make_frame(0, 0, 6'h00, 32'h1), 48, rx);
    f = make_frame(1, 1, `RB_CODEC_CMD_ADDR, $random(seed)) << 8;
    send_frame(f, 40, rx);
    no_write(300);
    check_eq(i_radioberry_tx_core.run, 1'b0, "run after short frame");
    check_eq(i_radioberry_tx_core.ptt, 1'b0, "ptt after short frame");
    check_eq(io_ptt_out, 1'b0, "io_ptt_out after short frame");
  endtask

  initial begin
    rst_n       = 1'b0;
    pi_spi_sck  = 1'b0;
    pi_spi_mosi = 1'b0;
    pi_spi_ce   = 2'b11;
    pi_tx_data  = 4'h0;
    nib_cnt     = 0;
    word_cnt    = 0;
    words_seen  = 0;
    repeat (10) @(posedge pi_tx_clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge pi_tx_clk);
    test_version();
    test_host_write();
    test_ptt();
    test_arbitration();
    test_packing();
    test_bad_frame();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/radio_pkg.sv
hw/spi_cmd_slave.sv
hw/tx_stream_packer.sv
hw/ptt_sequencer.sv
hw/ctrl_port_arbiter.sv
hw/ad9866_ctrl_serializer.sv
hw/radioberry_tx_core.sv
testbench/radioberry_tx_core_chk.sv
testbench/tb_radioberry_tx_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the TX core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
  --top-module tb_radioberry_tx_core -Mdir obj_dir -f src.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vtb_radioberry_tx_core
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0
